/* src/opll_bus_pkg.sv */
package opll_bus_pkg;

	localparam int BUS_W = 8;

	// upper address nibble of the channel register groups
	localparam logic [3:0] GRP_FNUM_LO = 4'h1;
	localparam logic [3:0] GRP_FNUM_HI = 4'h2;
	localparam logic [3:0] GRP_INST    = 4'h3;

	// custom instrument multiplier registers
	localparam logic [BUS_W-1:0] ADDR_CUST_MOD = 8'h00;
	localparam logic [BUS_W-1:0] ADDR_CUST_CAR = 8'h01;

	// latched address byte, read raw or as group and channel
	typedef union packed
	{
		logic [BUS_W-1:0] raw;
		struct packed
		{
			logic [3:0] grp;
			logic [3:0] chan;
		} addr;
	} bus_word_u;

endpackage

/* src/opll_voice_pkg.sv */
package opll_voice_pkg;

	localparam int FNUM_W   = 9;
	localparam int BLK_W    = 3;
	localparam int MULT_W   = 4;
	localparam int INST_W   = 4;
	localparam int PHASE_W  = 19;
	localparam int PG_OUT_W = 10;
	localparam int SLOT_W   = 5;
	localparam int CH_W     = 4;

	// twice the frequency multiple, so that code 0 gives one half
	localparam logic [MULT_W:0] MULT_X2_TABLE [16] = '{
		5'd1,  5'd2,  5'd4,  5'd6,
		5'd8,  5'd10, 5'd12, 5'd14,
		5'd16, 5'd18, 5'd20, 5'd20,
		5'd24, 5'd24, 5'd30, 5'd30
	};

	// {modulator, carrier} multiplier codes per instrument
	// entry 0 is unused, instrument 0 takes the custom registers
	localparam logic [2*MULT_W-1:0] INST_MULT_ROM [16] = '{
		8'h00,
		8'h11,
		8'h31,
		8'h31,
		8'h11,
		8'h21,
		8'h12,
		8'h11,
		8'h31,
		8'h11,
		8'h11,
		8'h31,
		8'h71,
		8'h10,
		8'h11,
		8'h11
	};

endpackage

/* src/opll_bus_write.sv */
`timescale 1ns/1ps

module opll_bus_write
#(
	parameter int NUM_CHANNELS = 9
)
(
	input  logic                              MCLK,
	input  logic                              rst_n,
	input  logic                              cs_n,
	input  logic                              we_n,
	input  logic                              a0,
	input  logic [opll_bus_pkg::BUS_W-1:0]    data_in,
	output logic                              cust_mod_wr,
	output logic                              cust_car_wr,
	output logic                              fnum_lo_wr,
	output logic                              fnum_hi_wr,
	output logic                              inst_wr,
	output logic [opll_voice_pkg::CH_W-1:0]   wr_chan,
	output logic [opll_bus_pkg::BUS_W-1:0]    wr_data
);
	import opll_bus_pkg::*;

	bus_word_u addr_q;
	logic      wr_en;
	logic      data_wr;
	logic      chan_ok;

	assign wr_en   = ~cs_n & ~we_n;
	assign data_wr = wr_en & a0;
	// channel groups only exist for populated channels
	assign chan_ok = int'(addr_q.addr.chan) < NUM_CHANNELS;

	always_ff @(posedge MCLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			addr_q.raw  <= '0;
			cust_mod_wr <= 1'b0;
			cust_car_wr <= 1'b0;
			fnum_lo_wr  <= 1'b0;
			fnum_hi_wr  <= 1'b0;
			inst_wr     <= 1'b0;
		end
		else
		begin
			if (wr_en && !a0)
				addr_q.raw <= data_in;
			// at most one strobe per data write
			cust_mod_wr <= data_wr && (addr_q.raw == ADDR_CUST_MOD);
			cust_car_wr <= data_wr && (addr_q.raw == ADDR_CUST_CAR);
			fnum_lo_wr  <= data_wr && chan_ok && (addr_q.addr.grp == GRP_FNUM_LO);
			fnum_hi_wr  <= data_wr && chan_ok && (addr_q.addr.grp == GRP_FNUM_HI);
			inst_wr     <= data_wr && chan_ok && (addr_q.addr.grp == GRP_INST);
		end
	end

	always_ff @(posedge MCLK)
	begin
		if (data_wr)
		begin
			wr_chan <= addr_q.addr.chan;
			wr_data <= data_in;
		end
	end

endmodule

/* src/opll_slot_seq.sv */
`timescale 1ns/1ps

module opll_slot_seq
#(
	parameter int NUM_CHANNELS = 9
)
(
	input  logic                              MCLK,
	input  logic                              rst_n,
	output logic [opll_voice_pkg::SLOT_W-1:0] slot,
	output logic [opll_voice_pkg::CH_W-1:0]   chan,
	output logic                              is_car
);
	import opll_voice_pkg::*;

	localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(2 * NUM_CHANNELS - 1);

	always_ff @(posedge MCLK or negedge rst_n)
	begin
		if (!rst_n)
			slot <= '0;
		else if (slot == LAST_SLOT)
			slot <= '0;
		else
			slot <= slot + SLOT_W'(1);
	end

	// even slots modulate, odd slots carry
	assign chan   = CH_W'(slot >> 1);
	assign is_car = slot[0];

endmodule

/* src/opll_reg_file.sv */
`timescale 1ns/1ps

module opll_reg_file
#(
	parameter int NUM_CHANNELS = 9
)
(
	input  logic                              MCLK,
	input  logic                              rst_n,
	input  logic                              cust_mod_wr,
	input  logic                              cust_car_wr,
	input  logic                              fnum_lo_wr,
	input  logic                              fnum_hi_wr,
	input  logic                              inst_wr,
	input  logic [opll_voice_pkg::CH_W-1:0]   wr_chan,
	input  logic [opll_bus_pkg::BUS_W-1:0]    wr_data,
	input  logic [opll_voice_pkg::CH_W-1:0]   chan,
	output logic [opll_voice_pkg::MULT_W-1:0] cust_mod_mult,
	output logic [opll_voice_pkg::MULT_W-1:0] cust_car_mult,
	output logic [opll_voice_pkg::FNUM_W-1:0] ch_fnum,
	output logic [opll_voice_pkg::BLK_W-1:0]  ch_blk,
	output logic                              ch_key_on,
	output logic [opll_voice_pkg::INST_W-1:0] ch_inst
);
	import opll_voice_pkg::*;

	logic [MULT_W-1:0] cust_mod_q;
	logic [MULT_W-1:0] cust_car_q;
	logic [FNUM_W-2:0] fnum_lo_q [NUM_CHANNELS];
	logic              fnum8_q   [NUM_CHANNELS];
	logic [BLK_W-1:0]  blk_q     [NUM_CHANNELS];
	logic              key_q     [NUM_CHANNELS];
	logic [INST_W-1:0] inst_q    [NUM_CHANNELS];

	always_ff @(posedge MCLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cust_mod_q <= '0;
			cust_car_q <= '0;
			for (int i = 0; i < NUM_CHANNELS; i++)
			begin
				fnum_lo_q[i] <= '0;
				fnum8_q[i]   <= 1'b0;
				blk_q[i]     <= '0;
				key_q[i]     <= 1'b0;
				inst_q[i]    <= '0;
			end
		end
		else
		begin
			if (cust_mod_wr)
				cust_mod_q <= wr_data[MULT_W-1:0];
			if (cust_car_wr)
				cust_car_q <= wr_data[MULT_W-1:0];
			if (fnum_lo_wr)
				fnum_lo_q[wr_chan] <= wr_data[FNUM_W-2:0];
			// 0x20 group: key-on, block, fnum msb
			if (fnum_hi_wr)
			begin
				key_q[wr_chan]   <= wr_data[4];
				blk_q[wr_chan]   <= wr_data[BLK_W:1];
				fnum8_q[wr_chan] <= wr_data[0];
			end
			// instrument sits in the upper nibble
			if (inst_wr)
				inst_q[wr_chan] <= wr_data[7:8-INST_W];
		end
	end

	assign cust_mod_mult = cust_mod_q;
	assign cust_car_mult = cust_car_q;
	assign ch_fnum       = {fnum8_q[chan], fnum_lo_q[chan]};
	assign ch_blk        = blk_q[chan];
	assign ch_key_on     = key_q[chan];
	assign ch_inst       = inst_q[chan];

endmodule

/* src/opll_operator_select.sv */
`timescale 1ns/1ps

module opll_operator_select
(
	input  logic                              MCLK,
	input  logic                              rst_n,
	input  logic [opll_voice_pkg::SLOT_W-1:0] slot,
	input  logic                              is_car,
	input  logic [opll_voice_pkg::MULT_W-1:0] cust_mod_mult,
	input  logic [opll_voice_pkg::MULT_W-1:0] cust_car_mult,
	input  logic [opll_voice_pkg::FNUM_W-1:0] ch_fnum,
	input  logic [opll_voice_pkg::BLK_W-1:0]  ch_blk,
	input  logic                              ch_key_on,
	input  logic [opll_voice_pkg::INST_W-1:0] ch_inst,
	output logic [opll_voice_pkg::SLOT_W-1:0] s1_slot,
	output logic [opll_voice_pkg::MULT_W:0]   s1_mult_x2,
	output logic [opll_voice_pkg::FNUM_W-1:0] s1_fnum,
	output logic [opll_voice_pkg::BLK_W-1:0]  s1_blk,
	output logic                              s1_key_on,
	output logic                              s1_valid
);
	import opll_voice_pkg::*;

	logic [2*MULT_W-1:0] rom_entry;
	logic [MULT_W-1:0]   mult_code;

	always_comb
	begin
		rom_entry = INST_MULT_ROM[ch_inst];
		// instrument 0 is the user patch
		if (ch_inst == '0)
			mult_code = is_car ? cust_car_mult : cust_mod_mult;
		else
			mult_code = is_car ? rom_entry[MULT_W-1:0] : rom_entry[2*MULT_W-1:MULT_W];
	end

	always_ff @(posedge MCLK or negedge rst_n)
	begin
		if (!rst_n)
			s1_valid <= 1'b0;
		else
			s1_valid <= 1'b1;
	end

	always_ff @(posedge MCLK)
	begin
		s1_slot    <= slot;
		s1_mult_x2 <= MULT_X2_TABLE[mult_code];
		s1_fnum    <= ch_fnum;
		s1_blk     <= ch_blk;
		s1_key_on  <= ch_key_on;
	end

endmodule

/* src/opll_phase_gen.sv */
`timescale 1ns/1ps

module opll_phase_gen
#(
	parameter int NUM_CHANNELS = 9
)
(
	input  logic                                MCLK,
	input  logic                                rst_n,
	input  logic [opll_voice_pkg::SLOT_W-1:0]   s1_slot,
	input  logic [opll_voice_pkg::MULT_W:0]     s1_mult_x2,
	input  logic [opll_voice_pkg::FNUM_W-1:0]   s1_fnum,
	input  logic [opll_voice_pkg::BLK_W-1:0]    s1_blk,
	input  logic                                s1_key_on,
	input  logic                                s1_valid,
	output logic [opll_voice_pkg::SLOT_W-1:0]   slot_out,
	output logic [opll_voice_pkg::PG_OUT_W-1:0] phase_out,
	output logic                                out_valid
);
	import opll_voice_pkg::*;

	localparam int NUM_SLOTS = 2 * NUM_CHANNELS;
	// fnum shifted by the largest block
	localparam int SH_W      = FNUM_W + (1 << BLK_W) - 1;
	localparam int PROD_W    = SH_W + MULT_W + 1;

	logic [PHASE_W-1:0] phase_mem [NUM_SLOTS];
	logic               key_hist  [NUM_SLOTS];
	logic [SH_W-1:0]    fnum_sh;
	logic [PROD_W-1:0]  prod;
	logic [PHASE_W-1:0] phase_inc;
	logic               key_edge;
	logic [PHASE_W-1:0] phase_nxt;

	always_comb
	begin
		fnum_sh   = SH_W'(s1_fnum) << s1_blk;
		prod      = PROD_W'(fnum_sh) * PROD_W'(s1_mult_x2);
		// halve to undo the x2 table, wrap at 2^19
		phase_inc = prod[PHASE_W:1];
		key_edge  = s1_key_on & ~key_hist[s1_slot];
		phase_nxt = key_edge ? '0 : phase_mem[s1_slot] + phase_inc;
	end

	always_ff @(posedge MCLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
			for (int i = 0; i < NUM_SLOTS; i++)
			begin
				phase_mem[i] <= '0;
				key_hist[i]  <= 1'b0;
			end
		end
		else
		begin
			out_valid <= s1_valid;
			if (s1_valid)
			begin
				phase_mem[s1_slot] <= phase_nxt;
				key_hist[s1_slot]  <= s1_key_on;
			end
		end
	end

	always_ff @(posedge MCLK)
	begin
		if (s1_valid)
		begin
			slot_out  <= s1_slot;
			phase_out <= phase_nxt[PHASE_W-1:PHASE_W-PG_OUT_W];
		end
	end

endmodule

/* src/opll_top.sv */
`timescale 1ns/1ps

module opll_top
#(
	parameter int NUM_CHANNELS = 9
)
(
	input  logic                                MCLK,
	input  logic                                rst_n,
	input  logic                                cs_n,
	input  logic                                we_n,
	input  logic                                a0,
	input  logic [opll_bus_pkg::BUS_W-1:0]      data_in,
	output logic [opll_voice_pkg::SLOT_W-1:0]   slot_out,
	output logic [opll_voice_pkg::PG_OUT_W-1:0] phase_out,
	output logic                                out_valid
);
	import opll_bus_pkg::*;
	import opll_voice_pkg::*;

	logic              cust_mod_wr;
	logic              cust_car_wr;
	logic              fnum_lo_wr;
	logic              fnum_hi_wr;
	logic              inst_wr;
	logic [CH_W-1:0]   wr_chan;
	logic [BUS_W-1:0]  wr_data;

	logic [SLOT_W-1:0] slot;
	logic [CH_W-1:0]   chan;
	logic              is_car;

	logic [MULT_W-1:0] cust_mod_mult;
	logic [MULT_W-1:0] cust_car_mult;
	logic [FNUM_W-1:0] ch_fnum;
	logic [BLK_W-1:0]  ch_blk;
	logic              ch_key_on;
	logic [INST_W-1:0] ch_inst;

	logic [SLOT_W-1:0] s1_slot;
	logic [MULT_W:0]   s1_mult_x2;
	logic [FNUM_W-1:0] s1_fnum;
	logic [BLK_W-1:0]  s1_blk;
	logic              s1_key_on;
	logic              s1_valid;

	opll_bus_write #(
		.NUM_CHANNELS(NUM_CHANNELS)
	) u_bus_write (
		.MCLK(MCLK), .rst_n(rst_n), .cs_n(cs_n), .we_n(we_n), .a0(a0), .data_in(data_in),
		.cust_mod_wr(cust_mod_wr), .cust_car_wr(cust_car_wr), .fnum_lo_wr(fnum_lo_wr),
		.fnum_hi_wr(fnum_hi_wr), .inst_wr(inst_wr), .wr_chan(wr_chan), .wr_data(wr_data)
	);

	opll_slot_seq #(
		.NUM_CHANNELS(NUM_CHANNELS)
	) u_slot_seq (
		.MCLK(MCLK), .rst_n(rst_n), .slot(slot), .chan(chan), .is_car(is_car)
	);

	opll_reg_file #(
		.NUM_CHANNELS(NUM_CHANNELS)
	) u_reg_file (
		.MCLK(MCLK), .rst_n(rst_n), .cust_mod_wr(cust_mod_wr), .cust_car_wr(cust_car_wr),
		.fnum_lo_wr(fnum_lo_wr), .fnum_hi_wr(fnum_hi_wr), .inst_wr(inst_wr),
		.wr_chan(wr_chan), .wr_data(wr_data), .chan(chan),
		.cust_mod_mult(cust_mod_mult), .cust_car_mult(cust_car_mult), .ch_fnum(ch_fnum),
		.ch_blk(ch_blk), .ch_key_on(ch_key_on), .ch_inst(ch_inst)
	);

	opll_operator_select u_operator_select (
		.MCLK(MCLK), .rst_n(rst_n), .slot(slot), .is_car(is_car),
		.cust_mod_mult(cust_mod_mult), .cust_car_mult(cust_car_mult), .ch_fnum(ch_fnum),
		.ch_blk(ch_blk), .ch_key_on(ch_key_on), .ch_inst(ch_inst),
		.s1_slot(s1_slot), .s1_mult_x2(s1_mult_x2), .s1_fnum(s1_fnum), .s1_blk(s1_blk),
		.s1_key_on(s1_key_on), .s1_valid(s1_valid)
	);

	opll_phase_gen #(
		.NUM_CHANNELS(NUM_CHANNELS)
	) u_phase_gen (
		.MCLK(MCLK), .rst_n(rst_n), .s1_slot(s1_slot), .s1_mult_x2(s1_mult_x2),
		.s1_fnum(s1_fnum), .s1_blk(s1_blk), .s1_key_on(s1_key_on), .s1_valid(s1_valid),
		.slot_out(slot_out), .phase_out(phase_out), .out_valid(out_valid)
	);

endmodule

/* dv/opll_tb.sv */
`timescale 1ns/1ps

module opll_tb;
	import opll_bus_pkg::*;
	import opll_voice_pkg::*;

	localparam int NCH = 9;
	// twice the frequency multiple per code
	localparam int X2_REF [16] = '{1, 2, 4, 6, 8, 10, 12, 14, 16, 18, 20, 20, 24, 24, 30, 30};

	logic                MCLK = 1'b0;
	logic                rst_n;
	logic                cs_n;
	logic                we_n;
	logic                a0;
	logic [BUS_W-1:0]    data_in;
	logic [SLOT_W-1:0]   slot_out;
	logic [PG_OUT_W-1:0] phase_out;
	logic                out_valid;

	logic [31:0] lcg_state = 32'd39;
	int          slot_errs = 0;
	int          phase_errs = 0;
	int          valid_errs = 0;
	int          other_errs = 0;
	bit          valid_seen;

	// reference model
	bus_word_u  m_addr;
	int         m_wr_kind;
	int         m_wr_ch;
	logic [7:0] m_wr_data;
	int         m_cmod;
	int         m_ccar;
	int         m_fnum [];
	int         m_blk [];
	int         m_key [];
	int         m_inst [];
	int         m_slot;
	int         p_slot;
	int         p_x2;
	int         p_fnum;
	int         p_blk;
	int         p_key;
	bit         p_valid;
	int         m_phase [];
	int         m_hist [];
	bit         m_valid;
	int         m_slot_out;
	int         m_phase_out;

	opll_top #(.NUM_CHANNELS(NCH)) dut0 (
		.MCLK(MCLK), .rst_n(rst_n), .cs_n(cs_n), .we_n(we_n), .a0(a0), .data_in(data_in),
		.slot_out(slot_out), .phase_out(phase_out), .out_valid(out_valid)
	);

	always #50 MCLK = ~MCLK;

	function automatic int rnd(input int n);
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return int'(lcg_state[30:16]) % n;
	endfunction

	// one rising edge of the whole chip with later stages first
	function automatic void model_edge();
		int         ch;
		int         code;
		logic [7:0] rom_e;
		if (!rst_n)
		begin
			m_addr.raw = '0;
			m_wr_kind = 0;
			m_cmod = 0;
			m_ccar = 0;
			m_slot = 0;
			p_valid = 1'b0;
			m_valid = 1'b0;
			m_fnum = new[NCH];
			m_blk = new[NCH];
			m_key = new[NCH];
			m_inst = new[NCH];
			m_phase = new[2 * NCH];
			m_hist = new[2 * NCH];
			return;
		end
		if (p_valid)
		begin
			if (p_key != 0 && m_hist[p_slot] == 0)
				m_phase[p_slot] = 0;
			else
				m_phase[p_slot] = (m_phase[p_slot] + (((p_fnum << p_blk) * p_x2) >> 1)) & 'h7FFFF;
			m_hist[p_slot] = p_key;
			m_slot_out = p_slot;
			m_phase_out = m_phase[p_slot] >> 9;
		end
		m_valid = p_valid;
		ch = m_slot / 2;
		rom_e = INST_MULT_ROM[4'(m_inst[ch])];
		if (m_inst[ch] == 0)
			code = (m_slot % 2 == 1) ? m_ccar : m_cmod;
		else
			code = (m_slot % 2 == 1) ? int'(rom_e[3:0]) : int'(rom_e[7:4]);
		p_slot = m_slot;
		p_x2 = X2_REF[4'(code)];
		p_fnum = m_fnum[ch];
		p_blk = m_blk[ch];
		p_key = m_key[ch];
		p_valid = 1'b1;
		case (m_wr_kind)
			1: m_cmod = int'(m_wr_data[3:0]);
			2: m_ccar = int'(m_wr_data[3:0]);
			3: m_fnum[m_wr_ch] = (m_fnum[m_wr_ch] & 256) | int'(m_wr_data);
			4:
			begin
				m_key[m_wr_ch] = int'(m_wr_data[4]);
				m_blk[m_wr_ch] = int'(m_wr_data[3:1]);
				m_fnum[m_wr_ch] = (m_fnum[m_wr_ch] & 255) | (int'(m_wr_data[0]) << 8);
			end
			5: m_inst[m_wr_ch] = int'(m_wr_data[7:4]);
			default: ;
		endcase
		m_wr_kind = 0;
		if (!cs_n && !we_n && !a0)
			m_addr.raw = data_in;
		else if (!cs_n && !we_n)
		begin
			m_wr_ch = int'(m_addr.addr.chan);
			m_wr_data = data_in;
			if (m_addr.raw == ADDR_CUST_MOD)
				m_wr_kind = 1;
			else if (m_addr.raw == ADDR_CUST_CAR)
				m_wr_kind = 2;
			else if (m_wr_ch < NCH && m_addr.addr.grp inside {GRP_FNUM_LO, GRP_FNUM_HI, GRP_INST})
				m_wr_kind = int'(m_addr.addr.grp) + 2;
		end
		m_slot = (m_slot + 1) % (2 * NCH);
	endfunction

	task automatic check_slot(input logic [SLOT_W-1:0] got, input logic [SLOT_W-1:0] exp);
		if (got !== exp)
		begin
			slot_errs++;
			$display("MISMATCH %0t slot_out got %0d expected %0d", $time, got, exp);
		end
	endtask

	task automatic check_phase(input logic [PG_OUT_W-1:0] got, input logic [PG_OUT_W-1:0] exp);
		if (got !== exp)
		begin
			phase_errs++;
			$display("MISMATCH %0t phase_out got %0d expected %0d", $time, got, exp);
		end
	endtask

	task automatic check_valid(input logic got, input logic exp);
		if (got !== exp)
		begin
			valid_errs++;
			$display("MISMATCH %0t out_valid got %b expected %b", $time, got, exp);
		end
	endtask

	// drive for the next rising edge, then check at the falling edge after it
	task automatic cycle(input logic c, input logic w, input logic a, input logic [BUS_W-1:0] d);
		cs_n = c;
		we_n = w;
		a0 = a;
		data_in = d;
		@(negedge MCLK);
		model_edge();
		check_valid(out_valid, m_valid);
		if (m_valid)
		begin
			check_slot(slot_out, SLOT_W'(m_slot_out));
			check_phase(phase_out, PG_OUT_W'(m_phase_out));
		end
	endtask

	task automatic idle(input int n);
		int sel;
		repeat (n)
		begin
			// never both strobes low
			sel = rnd(3);
			cycle(sel == 1 ? 1'b0 : 1'b1, sel == 2 ? 1'b0 : 1'b1, 1'(rnd(2)), 8'(rnd(256)));
		end
	endtask

	task automatic reg_write(input logic [BUS_W-1:0] addr, input logic [BUS_W-1:0] data);
		cycle(1'b0, 1'b0, 1'b0, addr);
		cycle(1'b0, 1'b0, 1'b1, data);
	endtask

	task automatic random_write(input bit with_inst);
		int               ch;
		int               kind;
		logic [BUS_W-1:0] d;
		ch = rnd(NCH);
		kind = rnd(with_inst ? 4 : 3);
		d = 8'(rnd(256));
		case (kind)
			0: reg_write(d[4] ? ADDR_CUST_CAR : ADDR_CUST_MOD, 8'(rnd(256)));
			1: reg_write({GRP_FNUM_LO, 4'(ch)}, d);
			2: reg_write({GRP_FNUM_HI, 4'(ch)}, d);
			default: reg_write({GRP_INST, 4'(ch)}, {4'(1 + rnd(15)), d[3:0]});
		endcase
	endtask

	task automatic unmapped_write();
		int               r;
		logic [BUS_W-1:0] addr;
		r = rnd(3);
		if (r == 0)
			addr = 8'(2 + rnd(14));
		else if (r == 1)
			addr = {4'(1 + rnd(3)), 4'(NCH + rnd(16 - NCH))};
		else
			addr = 8'(64 + rnd(192));
		reg_write(addr, 8'(rnd(256)));
	endtask

	task automatic wait_valid(output bit ok);
		int n;
		ok = 1'b0;
		n = 0;
		while (!ok && n < 10)
		begin
			idle(1);
			ok = out_valid;
			n++;
		end
		if (!ok)
		begin
			other_errs++;
			$display("ERROR: out_valid did not rise within %0d cycles after reset release", n);
		end
	endtask

	initial
	begin
		cs_n = 1'b1;
		we_n = 1'b1;
		a0 = 1'b0;
		data_in = '0;
		rst_n = 1'b0;
		idle(16);
		rst_n = 1'b1;
		wait_valid(valid_seen);
		if (valid_seen)
		begin
			idle(2 * NCH + 4);
			// custom patch only
			repeat (80)
			begin
				random_write(1'b0);
				idle(rnd(12));
			end
			repeat (80)
			begin
				random_write(1'b1);
				idle(rnd(12));
			end
			// key off long enough for both slots, then key on
			for (int ch = 0; ch < NCH; ch++)
			begin
				reg_write({GRP_FNUM_HI, 4'(ch)}, {4'h0, 4'(rnd(16))});
				idle(2 * NCH + 2);
				reg_write({GRP_FNUM_HI, 4'(ch)}, {4'h1, 4'(rnd(16))});
				idle(rnd(6));
			end
			repeat (40)
			begin
				unmapped_write();
				idle(rnd(8));
			end
			idle(4 * NCH);
		end
		$display("errors: slot %0d, phase %0d, valid %0d, other %0d",
			slot_errs, phase_errs, valid_errs, other_errs);
		if (slot_errs + phase_errs + valid_errs + other_errs == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* opll_top.f */
src/opll_bus_pkg.sv
src/opll_voice_pkg.sv
src/opll_bus_write.sv
src/opll_slot_seq.sv
src/opll_reg_file.sv
src/opll_operator_select.sv
src/opll_phase_gen.sv
src/opll_top.sv
dv/opll_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --top-module opll_tb -f opll_top.f
./obj_dir/Vopll_tb | tee sim.log
if grep -q "Simulation failed" sim.log
then
	echo "testbench reported errors, see sim.log" >&2
	exit 1
fi
exit 0
